//--- list.f
hdl/exec_pkg.sv
hdl/alu_chaos.sv
hdl/alu.sv
hdl/key_store.sv
hdl/branch_unit.sv
hdl/exec_stage.sv
tests/exec_stage_checker.sv
tests/exec_stage_tb.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  # Design, package first
  - files:
      - hdl/exec_pkg.sv
      - hdl/alu_chaos.sv
      - hdl/alu.sv
      - hdl/key_store.sv
      - hdl/branch_unit.sv
      - hdl/exec_stage.sv

  # Simulation only
  - target: test
    files:
      - tests/exec_stage_checker.sv
      - tests/exec_stage_tb.sv

//--- tests/exec_stage_tb.sv
`timescale 1ns/1ps

module exec_stage_tb;

  // About 1300 cycles of tests plus margin
  localparam int MAX_CYCLES = 2000;

  // Expected record and the cycle it should show up in
  typedef struct packed {
    exec_pkg::ex_mem_t rec;
    logic [31:0]       cyc;
  } expect_t;

  logic                clk;
  logic                rst_n;
  logic                id_valid;
  exec_pkg::id_ex_t    id_ex;
  logic                key_wr;
  exec_pkg::key_idx_t  key_idx;
  exec_pkg::key_word_t key_word;
  exec_pkg::ex_mem_t   ex_mem;

  exec_pkg::key_t key_copy;
  integer         seed;
  logic [31:0]    cycles = '0;
  expect_t        exp_q[$];

  exec_stage uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .id_valid (id_valid),
    .id_ex    (id_ex),
    .key_wr   (key_wr),
    .key_idx  (key_idx),
    .key_word (key_word),
    .ex_mem   (ex_mem)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Clock, cycle count and timeout
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      stop_failed();
    end
  end

  task automatic stop_failed();
    $display("*** FAILED ***");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_eq(input string what, input logic [31:0] got,
                          input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
      stop_failed();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Plain RV32 semantics by op code
  function automatic exec_pkg::word_t plain_op(input logic [2:0] op,
                                               input exec_pkg::word_t a,
                                               input exec_pkg::word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      3'd0: plain_op = a + b;
      3'd1: plain_op = a - b;
      3'd2: plain_op = a & b;
      3'd3: plain_op = a | b;
      3'd4: plain_op = a ^ b;
      3'd5: plain_op = a << sh;
      3'd6: plain_op = a >> sh;
      // Logical shift with sign bits filled in from the top
      default: plain_op = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
    endcase
  endfunction

  function automatic exec_pkg::ex_mem_t expect_rec(input exec_pkg::id_ex_t it,
                                                   input exec_pkg::key_t k);
    exec_pkg::ex_mem_t r;
    logic [2:0]        phys;
    logic              ltu;
    logic              eq;
    phys = k[3 * int'(it.alusel) +: 3];
    ltu  = (it.a < it.b);
    eq   = (it.a == it.b);
    r = '0;
    r.valid    = 1'b1;
    r.comp_res = ltu;
    // Priority LUI, link, compare, keyed
    if (it.lui) r.res = it.b;
    else if (it.jal || it.jalr) r.res = {20'h0, it.pres_adr};
    else if (it.compare && ltu) r.res = 32'd1;
    else r.res = plain_op(phys, it.a ^ k[87:56], it.b) ^ k[55:24];
    if (it.branch) begin
      case (it.br_op)
        exec_pkg::BEQ:  r.br_taken = eq;
        exec_pkg::BNE:  r.br_taken = !eq;
        exec_pkg::BLTU: r.br_taken = ltu;
        default:        r.br_taken = !ltu;
      endcase
    end
    r.br_target = it.pres_adr + it.imm;
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Called 1 ns after a rising edge and returns 1 ns after the next one
  task automatic issue(input exec_pkg::id_ex_t it, input logic vld);
    expect_t e;
    id_ex    = it;
    id_valid = vld;
    if (vld) begin
      e.rec = expect_rec(it, key_copy);
      e.cyc = cycles + 2;
      exp_q.push_back(e);
    end
    @(posedge clk);
    #1;
    id_valid = 1'b0;
  endtask

  task automatic drain();
    exec_pkg::id_ex_t idle;
    int               waited;
    idle   = '0;
    waited = 0;
    // Two cycles of latency and one spare
    while (exp_q.size() > 0 && waited < 3) begin
      issue(idle, 1'b0);
      waited++;
    end
  endtask

  task automatic write_key(input exec_pkg::key_idx_t idx, input exec_pkg::key_word_t w);
    key_wr   = 1'b1;
    key_idx  = idx;
    key_word = w;
    // Index 3 leaves the key alone
    if (idx != 2'd3) key_copy[32 * int'(idx) +: 32] = w;
    @(posedge clk);
    #1;
    key_wr = 1'b0;
  endtask

  task automatic load_key(input exec_pkg::key_t k);
    drain();
    write_key(2'd0, k[31:0]);
    write_key(2'd1, k[63:32]);
    write_key(2'd2, k[95:64]);
  endtask

  task automatic rand_item(output exec_pkg::id_ex_t it, input logic mix, input logic br_mix);
    logic [31:0] r;
    r = $random(seed);
    it = '0;
    it.a        = $random(seed);
    it.b        = $random(seed);
    it.pres_adr = r[11:0];
    it.imm      = r[23:12];
    it.alusel   = exec_pkg::alu_op_e'(r[26:24]);
    r = $random(seed);
    if (mix) begin
      it.lui     = r[0] & r[1];
      it.jal     = r[2] & r[3];
      it.jalr    = r[4] & r[5];
      it.compare = r[6];
    end
    if (br_mix) begin
      it.branch = r[8] | r[9];
      it.br_op  = exec_pkg::br_op_e'(r[11:10]);
      // Equal operands half the time
      if (r[12]) it.b = it.a;
    end
  endtask

  task automatic run_items(input int n, input logic mix, input logic br_mix);
    exec_pkg::id_ex_t it;
    repeat (n) begin
      rand_item(it, mix, br_mix);
      issue(it, 1'b1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////////////////////

  // Sampled on the falling edge away from the register updates
  always @(negedge clk) begin
    expect_t e;
    if (rst_n && ex_mem.valid) begin
      if (exp_q.size() == 0) begin
        $display("output valid at %0t with no item in flight", $time);
        stop_failed();
      end else begin
        e = exp_q.pop_front();
        check_eq("arrival cycle", cycles, e.cyc);
        check_eq("res", ex_mem.res, e.rec.res);
        check_eq("comp_res", ex_mem.comp_res, e.rec.comp_res);
        check_eq("br_taken", ex_mem.br_taken, e.rec.br_taken);
        check_eq("br_target", ex_mem.br_target, e.rec.br_target);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    exec_pkg::id_ex_t it;
    exec_pkg::key_t   k;
    logic [31:0]      r;
    seed     = 32'ha2d7_8a7d;
    rst_n    = 1'b0;
    id_valid = 1'b0;
    id_ex    = '0;
    key_wr   = 1'b0;
    key_idx  = '0;
    key_word = '0;
    key_copy = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_eq("valid after reset", ex_mem.valid, 1'b0);

    // Every op collapses to ADD under the zero key
    run_items(20, 1'b0, 1'b0);

    // Plain RV32 behaviour under the identity key
    k = '0;
    for (int i = 0; i < 8; i++) k[3 * i +: 3] = 3'(i);
    load_key(k);
    run_items(300, 1'b0, 1'b0);

    // Wrong keys and ignored writes to index 3
    repeat (3) begin
      k = {$random(seed), $random(seed), $random(seed)};
      load_key(k);
      write_key(2'd3, $random(seed));
      run_items(100, 1'b0, 1'b0);
    end

    // Result priority under a random key
    run_items(200, 1'b1, 1'b0);

    // Branches of all kinds
    run_items(200, 1'b1, 1'b1);

    // Gaps in id_valid
    repeat (200) begin
      r = $random(seed);
      rand_item(it, 1'b1, 1'b1);
      issue(it, r[0] | r[1]);
    end
    drain();

    if (exp_q.size() == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("some expected outputs never arrived");
      stop_failed();
    end
  end

endmodule

//--- tests/exec_stage_checker.sv
`timescale 1ns/1ps

module exec_stage_checker (
  input logic              clk,
  input logic              rst_n,
  input logic              id_valid,
  input exec_pkg::id_ex_t  id_ex,
  input exec_pkg::ex_mem_t ex_mem
);

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline properties
  ////////////////////////////////////////////////////////////////////////////

  // Output record stays empty in reset
  reset_quiet: assert property (@(posedge clk) !rst_n |-> !ex_mem.valid)
    else $error("ex_mem.valid set during reset");

  // Two register stages from input to output
  valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
    id_valid |-> ##2 ex_mem.valid)
    else $error("id_valid not followed by ex_mem.valid two cycles later");

  // No output without an input two cycles back
  no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
    ex_mem.valid |-> $past(id_valid, 2))
    else $error("ex_mem.valid without a matching id_valid");

  // Taken only for branch items
  taken_needs_branch: assert property (@(posedge clk) disable iff (!rst_n)
    ex_mem.br_taken |-> $past(id_ex.branch, 2))
    else $error("br_taken set for a non-branch item");

endmodule

bind exec_stage exec_stage_checker u_checker (
  .clk      (clk),
  .rst_n    (rst_n),
  .id_valid (id_valid),
  .id_ex    (id_ex),
  .ex_mem   (ex_mem)
);

//--- hdl/exec_stage.sv
`timescale 1ns/1ps

module exec_stage #(
  parameter exec_pkg::key_t KEY_RESET = '0
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                id_valid,
  input  exec_pkg::id_ex_t    id_ex,
  input  logic                key_wr,
  input  exec_pkg::key_idx_t  key_idx,
  input  exec_pkg::key_word_t key_word,
  output exec_pkg::ex_mem_t   ex_mem
);

  ////////////////////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////////////////////

  exec_pkg::id_ex_t id_ex_q;
  logic             valid_q;

  // Captured every cycle since nothing stalls the stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_q <= '0;
      valid_q <= 1'b0;
    end else begin
      id_ex_q <= id_ex;
      valid_q <= id_valid;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Key store
  ////////////////////////////////////////////////////////////////////////////

  exec_pkg::key_t key;

  key_store #(
    .KEY_RESET (KEY_RESET)
  ) u_key_store (
    .clk      (clk),
    .rst_n    (rst_n),
    .key_wr   (key_wr),
    .key_idx  (key_idx),
    .key_word (key_word),
    .key      (key)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////////////////////////////

  exec_pkg::word_t res;
  logic            comp_res;
  logic            br_taken;
  exec_pkg::pc_t   br_target;

  // Locked ALU
  alu u_alu (
    .a        (id_ex_q.a),
    .b        (id_ex_q.b),
    .pres_adr (id_ex_q.pres_adr),
    .alusel   (id_ex_q.alusel),
    .lui      (id_ex_q.lui),
    .jal      (id_ex_q.jal),
    .jalr     (id_ex_q.jalr),
    .compare  (id_ex_q.compare),
    .key      (key),
    .res      (res),
    .comp_res (comp_res)
  );

  // Unsigned branch resolution and target
  branch_unit u_branch_unit (
    .a         (id_ex_q.a),
    .b         (id_ex_q.b),
    .branch    (id_ex_q.branch),
    .br_op     (id_ex_q.br_op),
    .pres_adr  (id_ex_q.pres_adr),
    .imm       (id_ex_q.imm),
    .br_taken  (br_taken),
    .br_target (br_target)
  );

  ////////////////////////////////////////////////////////////////////////////
  // EX/MEM register
  ////////////////////////////////////////////////////////////////////////////

  // Second stage of the two-cycle valid pipe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem <= '0;
    end else begin
      ex_mem.valid     <= valid_q;
      ex_mem.res       <= res;
      ex_mem.comp_res  <= comp_res;
      ex_mem.br_taken  <= br_taken;
      ex_mem.br_target <= br_target;
    end
  end

endmodule

//--- hdl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
  input  exec_pkg::word_t  a,
  input  exec_pkg::word_t  b,
  input  logic             branch,
  input  exec_pkg::br_op_e br_op,
  input  exec_pkg::pc_t    pres_adr,
  input  exec_pkg::pc_t    imm,
  output logic             br_taken,
  output exec_pkg::pc_t    br_target
);

  logic eq;
  logic ltu;
  logic cond;

  // Raw comparisons
  assign eq  = (a == b);
  assign ltu = (a < b);

  // Condition per branch kind
  // BNE and BGEU invert BEQ and BLTU
  always_comb begin
    case (br_op)
      exec_pkg::BEQ:  cond = eq;
      exec_pkg::BNE:  cond = !eq;
      exec_pkg::BLTU: cond = ltu;
      exec_pkg::BGEU: cond = !ltu;
      default:        cond = 1'b0;
    endcase
  end

  // Non-branch items never report taken
  assign br_taken = branch && cond;

  // Target wraps at the PC width
  assign br_target = pres_adr + imm;

endmodule

//--- hdl/key_store.sv
`timescale 1ns/1ps

module key_store #(
  parameter exec_pkg::key_t KEY_RESET = '0
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                key_wr,
  input  exec_pkg::key_idx_t  key_idx,
  input  exec_pkg::key_word_t key_word,
  output exec_pkg::key_t      key
);

  ////////////////////////////////////////////////////////////////////////////
  // Word-wise key register
  ////////////////////////////////////////////////////////////////////////////

  // Only indices below the word count write
  logic idx_ok;

  assign idx_ok = (int'(key_idx) < exec_pkg::KEY_WORDS);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Power-up key from the top level
      key <= KEY_RESET;
    end else if (key_wr && idx_ok) begin
      // Word 0 is bits 31:0 and word 2 is bits 95:64
      key[exec_pkg::KEY_WORD_W * key_idx +: exec_pkg::KEY_WORD_W] <= key_word;
    end
  end

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
  input  exec_pkg::word_t   a,
  input  exec_pkg::word_t   b,
  input  exec_pkg::pc_t     pres_adr,
  input  exec_pkg::alu_op_e alusel,
  input  logic              lui,
  input  logic              jal,
  input  logic              jalr,
  input  logic              compare,
  input  exec_pkg::key_t    key,
  output exec_pkg::word_t   res,
  output logic              comp_res
);

  exec_pkg::word_t keyed_res;

  // Unsigned compare flag, independent of the key
  assign comp_res = (a < b);

  // Locked operation core
  alu_chaos u_chaos (
    .a      (a),
    .b      (b),
    .opcode (alusel),
    .key    (key),
    .y      (keyed_res)
  );

  // Result select by priority from LUI down to the keyed result
  always_comb begin
    if (lui) begin
      res = b;
    end else if (jal || jalr) begin
      // Link address zero-extended to the data width
      res = exec_pkg::word_t'(pres_adr);
    end else if (compare && comp_res) begin
      res = exec_pkg::word_t'(1);
    end else begin
      res = keyed_res;
    end
  end

endmodule

//--- hdl/alu_chaos.sv
`timescale 1ns/1ps

module alu_chaos (
  input  exec_pkg::word_t   a,
  input  exec_pkg::word_t   b,
  input  exec_pkg::alu_op_e opcode,
  input  exec_pkg::key_t    key,
  output exec_pkg::word_t   y
);

  ////////////////////////////////////////////////////////////////////////////
  // Key fields
  ////////////////////////////////////////////////////////////////////////////

  exec_pkg::alu_op_e phys_op;
  exec_pkg::word_t   amask;
  exec_pkg::word_t   rmask;
  exec_pkg::word_t   a_m;
  exec_pkg::word_t   raw;
  logic [4:0]        shamt;

  // Remap entry picked by the decoded opcode
  assign phys_op = exec_pkg::alu_op_e'(
    key[exec_pkg::KEY_MAP_LSB + exec_pkg::KEY_MAP_W * opcode +: exec_pkg::KEY_MAP_W]);

  // Operand and result masks
  assign amask = key[exec_pkg::KEY_AMASK_LSB +: exec_pkg::XLEN];
  assign rmask = key[exec_pkg::KEY_RMASK_LSB +: exec_pkg::XLEN];

  // Operand a scrambled before the operation
  assign a_m = a ^ amask;

  // RV32 shifts use the low five bits only
  assign shamt = b[4:0];

  ////////////////////////////////////////////////////////////////////////////
  // Physical operation
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (phys_op)
      exec_pkg::ADD: raw = a_m + b;
      exec_pkg::SUB: raw = a_m - b;
      exec_pkg::AND: raw = a_m & b;
      exec_pkg::OR:  raw = a_m | b;
      exec_pkg::XOR: raw = a_m ^ b;
      exec_pkg::SLL: raw = a_m << shamt;
      exec_pkg::SRL: raw = a_m >> shamt;
      // Arithmetic shift keeps the sign of the masked operand
      exec_pkg::SRA: raw = exec_pkg::word_t'($signed(a_m) >>> shamt);
      default:       raw = a_m + b;
    endcase
  end

  // Result unscrambled on the way out
  assign y = raw ^ rmask;

endmodule

//--- hdl/exec_pkg.sv
package exec_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int XLEN = 32;
  localparam int PC_W = 12;
  localparam int KEY_W = 96;
  localparam int KEY_WORD_W = 32;
  // Loadable key words
  // Index 3 writes nothing
  localparam int KEY_WORDS = 3;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [PC_W-1:0] pc_t;
  typedef logic [KEY_W-1:0] key_t;
  typedef logic [KEY_WORD_W-1:0] key_word_t;
  typedef logic [1:0] key_idx_t;

  ////////////////////////////////////////////////////////////////////////////
  // Key field layout
  ////////////////////////////////////////////////////////////////////////////

  // Eight remap entries, one per alusel code
  localparam int KEY_MAP_LSB = 0;
  localparam int KEY_MAP_W = 3;
  // Result XOR mask
  localparam int KEY_RMASK_LSB = 24;
  // Operand-a XOR mask
  // Bits 95:88 left unused
  localparam int KEY_AMASK_LSB = 56;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings and pipeline records
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, SLL, SRL, SRA} alu_op_e;

  typedef enum logic [1:0] {BEQ, BNE, BLTU, BGEU} br_op_e;

  typedef struct packed {
    word_t   a;
    word_t   b;
    pc_t     pres_adr;
    pc_t     imm;
    alu_op_e alusel;
    logic    lui;
    logic    jal;
    logic    jalr;
    logic    compare;
    logic    branch;
    br_op_e  br_op;
  } id_ex_t;

  typedef struct packed {
    logic  valid;
    word_t res;
    logic  comp_res;
    logic  br_taken;
    pc_t   br_target;
  } ex_mem_t;

endpackage
